// File: hdl/mem_port_pkg.sv
// shared widths, bus encodings and request struct for the memory port, imported by each block
`default_nettype none

package mem_port_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////////////////////////

    // byte address on the memory bus
    localparam int addr_width = 32;
    // one data beat, a full double word
    localparam int line_width = 64;
    // transaction tag, zero reserved for none
    localparam int tag_width  = 4;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [line_width-1:0] line_t;
    typedef logic [tag_width-1:0]  mem_tag_t;

    // tag value meaning no transaction
    localparam mem_tag_t no_tag = '0;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // memory bus command, same codes as the processor bus
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_t;

    // access size on the bus
    typedef enum logic [1:0] {
        byte_size   = 2'd0,
        half_size   = 2'd1,
        word_size   = 2'd2,
        double_size = 2'd3
    } mem_size_t;

    // error status reported toward the outside
    typedef enum logic [1:0] {
        no_error      = 2'd0,
        illegal_inst  = 2'd1,
        halted_on_wfi = 2'd2
    } error_status_t;

    //////////////////////////////////////////////////////////////////////
    // request bundle
    //////////////////////////////////////////////////////////////////////

    // one bus request, as sent by the data side or synthesized for fetch
    typedef struct packed {
        bus_cmd_t  command;
        addr_t     addr;
        line_t     data;
        mem_size_t size;
    } mem_req_t;

    // every fetch pulls a whole double word
    localparam mem_size_t fetch_size = double_size;

endpackage

`default_nettype wire

// File: hdl/mem_port_top.sv
// top level of the shared memory port: connects capture, history and mux for fetch and data sides
`timescale 1ns/1ps
`default_nettype none

module mem_port_top (
    input  logic                        clock,
    input  logic                        reset,

    // fetch side request
    input  mem_port_pkg::addr_t         fetch_addr,
    // data cache side request
    input  mem_port_pkg::mem_req_t      data_req,

    // memory bus return path
    input  mem_port_pkg::mem_tag_t      mem_response,
    input  mem_port_pkg::mem_tag_t      mem_tag,
    input  mem_port_pkg::line_t         mem_rdata,

    // retire events
    input  logic                        halt,
    input  logic                        illegal,

    // memory bus request
    output mem_port_pkg::mem_req_t      mem_req,

    // steered responses
    output mem_port_pkg::mem_tag_t      fetch_response,
    output mem_port_pkg::mem_tag_t      data_response,

    // unsteered return data and tags, clients match tags themselves
    output mem_port_pkg::line_t         fetch_rdata,
    output mem_port_pkg::line_t         data_rdata,
    output mem_port_pkg::mem_tag_t      fetch_tag,
    output mem_port_pkg::mem_tag_t      data_tag,

    // fetch side held off while data owns the port
    output logic                        fetch_stall,
    output logic                        halted,
    output mem_port_pkg::error_status_t status
);

    //////////////////////////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////////////////////////

    // registered ownership, one cycle after the data command
    logic data_owner;
    // ownership one history step later
    logic data_owner_now;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    request_capture u_request_capture (
        .clock      (clock),
        .reset      (reset),
        .data_cmd   (data_req.command),
        .halt       (halt),
        .data_owner (data_owner),
        .halted     (halted)
    );

    //////////////////////////////////////////////////////////////////////
    // history and steering
    //////////////////////////////////////////////////////////////////////

    owner_history u_owner_history (
        .clock          (clock),
        .reset          (reset),
        .data_owner     (data_owner),
        .mem_response   (mem_response),
        .data_owner_now (data_owner_now),
        .fetch_response (fetch_response),
        .data_response  (data_response)
    );

    //////////////////////////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////////////////////////

    port_mux u_port_mux (
        .data_owner (data_owner),
        .halted     (halted),
        .illegal    (illegal),
        .fetch_addr (fetch_addr),
        .data_req   (data_req),
        .mem_req    (mem_req),
        .status     (status)
    );

    // stall follows the delayed owner, same view the steering uses
    assign fetch_stall = data_owner_now;

    // return data and tag go to both sides unchanged
    assign fetch_rdata = mem_rdata;
    assign data_rdata  = mem_rdata;
    assign fetch_tag   = mem_tag;
    assign data_tag    = mem_tag;

endmodule

`default_nettype wire

// File: hdl/owner_history.sv
// ownership history of the memory port; steers each memory response to the client that owned it
`timescale 1ns/1ps
`default_nettype none

module owner_history (
    input  logic                   clock,
    input  logic                   reset,
    // registered data-side ownership from the capture stage
    input  logic                   data_owner,
    // response tag straight from memory
    input  mem_port_pkg::mem_tag_t mem_response,
    output logic                   data_owner_now,
    output mem_port_pkg::mem_tag_t fetch_response,
    output mem_port_pkg::mem_tag_t data_response
);

    import mem_port_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // history flags
    //////////////////////////////////////////////////////////////////////

    // owner one history cycle further back
    logic data_owner_prev;

    // two-deep shift of the ownership flag
    // memory answers a request a cycle or so after it is sent,
    // so the response belongs to whoever owned the port back then
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_owner_now  <= 1'b0;
            data_owner_prev <= 1'b0;
        end else begin
            data_owner_now  <= data_owner;
            data_owner_prev <= data_owner_now;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response steering
    //////////////////////////////////////////////////////////////////////

    // stable owner in both slots gets the response
    // a mixed pair means the owner just changed hands
    always_comb begin
        fetch_response = no_tag;
        data_response  = no_tag;
        if (data_owner_now && data_owner_prev) begin
            // data side held the port two cycles in a row
            data_response = mem_response;
        end else if (!data_owner_now && !data_owner_prev) begin
            // fetch side held the port two cycles in a row
            fetch_response = mem_response;
        end
        // otherwise withheld from both
        // a nonzero tag here is dropped, clients retry
    end

endmodule

`default_nettype wire

// File: hdl/port_mux.sv
// output side of the memory port: picks data request or fetch load and encodes the error status
`timescale 1ns/1ps
`default_nettype none

module port_mux (
    input  logic                        data_owner,
    input  logic                        halted,
    // level from retire
    input  logic                        illegal,
    // instruction fetch address
    input  mem_port_pkg::addr_t         fetch_addr,
    // full request from the data side
    input  mem_port_pkg::mem_req_t      data_req,
    output mem_port_pkg::mem_req_t      mem_req,
    output mem_port_pkg::error_status_t status
);

    import mem_port_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // fetch request
    //////////////////////////////////////////////////////////////////////

    // synthesized fetch load
    mem_req_t fetch_req;

    always_comb begin
        // halted core stops fetching entirely
        if (halted) begin
            fetch_req.command = bus_none;
        end else begin
            fetch_req.command = bus_load;
        end
        fetch_req.addr = fetch_addr;
        // loads carry no write data
        fetch_req.data = '0;
        fetch_req.size = fetch_size;
    end

    //////////////////////////////////////////////////////////////////////
    // bus select
    //////////////////////////////////////////////////////////////////////

    // data side owns the port one cycle after its command appears
    // fields taken live from the data request in that cycle
    always_comb begin
        if (data_owner) begin
            mem_req = data_req;
        end else begin
            mem_req = fetch_req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // error status
    //////////////////////////////////////////////////////////////////////

    // data side has no command this cycle
    logic data_idle;

    assign data_idle = (data_req.command == bus_none);

    // illegal first, then halt once the data side has drained
    always_comb begin
        if (illegal) begin
            status = illegal_inst;
        end else if (halted && data_idle) begin
            status = halted_on_wfi;
        end else begin
            status = no_error;
        end
    end

endmodule

`default_nettype wire

// File: hdl/request_capture.sv
// input side of the memory port: registers data-side ownership and holds the sticky halt latch
`timescale 1ns/1ps
`default_nettype none

module request_capture (
    input  logic                   clock,
    input  logic                   reset,
    // command field of the data-side request
    input  mem_port_pkg::bus_cmd_t data_cmd,
    // one-cycle strobe from retire
    input  logic                   halt,
    output logic                   data_owner,
    output logic                   halted
);

    import mem_port_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // ownership request
    //////////////////////////////////////////////////////////////////////

    // data side asks for the port on any real command
    logic data_wants_port;

    assign data_wants_port = (data_cmd != bus_none);

    // port changes hands one cycle after the request shows up
    // data side always wins, fetch gets whatever is left
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_owner <= 1'b0;
        end else begin
            data_owner <= data_wants_port;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // halt latch
    //////////////////////////////////////////////////////////////////////

    // sticky until reset
    // set on the edge after the strobe
    // blocks fetch loads downstream and feeds the status encoder
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the memory port testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module mem_port_tb -o mem_port_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/mem_port_sim > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation ok"

// File: sim/mem_port_properties.sv
// concurrent checks on ownership history and response steering, bound into owner_history
`timescale 1ns/1ps
`default_nettype none

module mem_port_properties (
    input logic                   clock,
    input logic                   reset,
    input logic                   data_owner_now,
    input logic                   data_owner_prev,
    input mem_port_pkg::mem_tag_t fetch_response,
    input mem_port_pkg::mem_tag_t data_response
);

    import mem_port_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // steering
    //////////////////////////////////////////////////////////////////////

    // one client at most
    responses_exclusive: assert property (@(posedge clock) disable iff (reset)
        !((fetch_response != no_tag) && (data_response != no_tag)))
        else $error("fetch and data responses nonzero together");

    // data needs two cycles of data ownership
    data_needs_history: assert property (@(posedge clock) disable iff (reset)
        (data_response != no_tag) |-> (data_owner_now && data_owner_prev))
        else $error("data response without stable data ownership");

    // fetch needs two cycles of fetch ownership
    fetch_needs_history: assert property (@(posedge clock) disable iff (reset)
        (fetch_response != no_tag) |-> (!data_owner_now && !data_owner_prev))
        else $error("fetch response without stable fetch ownership");

endmodule

bind owner_history mem_port_properties u_properties (
    .clock           (clock),
    .reset           (reset),
    .data_owner_now  (data_owner_now),
    .data_owner_prev (data_owner_prev),
    .fetch_response  (fetch_response),
    .data_response   (data_response)
);

`default_nettype wire

// File: sim/mem_port_tb.sv
// table-driven testbench for the shared memory port; compile with verilog.f, top is mem_port_tb
`timescale 1ns/1ps
`default_nettype none

module mem_port_tb;

    import mem_port_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////////////////////////

    logic          clock;
    logic          reset;
    addr_t         fetch_addr;
    mem_req_t      data_req;
    mem_tag_t      mem_response;
    mem_tag_t      mem_tag;
    line_t         mem_rdata;
    logic          halt;
    logic          illegal;
    mem_req_t      mem_req;
    mem_tag_t      fetch_response;
    mem_tag_t      data_response;
    line_t         fetch_rdata;
    line_t         data_rdata;
    mem_tag_t      fetch_tag;
    mem_tag_t      data_tag;
    logic          fetch_stall;
    logic          halted;
    error_status_t status;

    mem_port_top u_dut (
        .clock          (clock),
        .reset          (reset),
        .fetch_addr     (fetch_addr),
        .data_req       (data_req),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .mem_rdata      (mem_rdata),
        .halt           (halt),
        .illegal        (illegal),
        .mem_req        (mem_req),
        .fetch_response (fetch_response),
        .data_response  (data_response),
        .fetch_rdata    (fetch_rdata),
        .data_rdata     (data_rdata),
        .fetch_tag      (fetch_tag),
        .data_tag       (data_tag),
        .fetch_stall    (fetch_stall),
        .halted         (halted),
        .status         (status)
    );

    // one table row, one clock cycle of stimulus
    typedef struct packed {
        bus_cmd_t cmd;
        logic     halt_strobe;
        logic     illegal_level;
        // random nonzero response tag when set, none otherwise
        logic     respond;
    } row_t;

    row_t stimulus [$];

    // model of the port registers
    logic     model_owner;
    logic     model_now;
    logic     model_prev;
    logic     model_halted;
    // inputs held during the current cycle
    bus_cmd_t last_cmd;
    logic     last_halt;
    int       step;
    int       check_count;

    // 10 ns clock
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // error reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_req(input mem_req_t actual, input mem_req_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t: step %0d %s is %h, expected %h",
                $time, step, what, actual, expected));
        end
    endtask

    task automatic check_tag(input mem_tag_t actual, input mem_tag_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t: step %0d %s is %h, expected %h",
                $time, step, what, actual, expected));
        end
    endtask

    task automatic check_line(input line_t actual, input line_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t: step %0d %s is %h, expected %h",
                $time, step, what, actual, expected));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t: step %0d %s is %b, expected %b",
                $time, step, what, actual, expected));
        end
    endtask

    task automatic check_status(input error_status_t actual, input error_status_t expected,
                                input string what);
        check_count++;
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t: step %0d %s is %s, expected %s",
                $time, step, what, actual.name(), expected.name()));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // one rising edge of the port registers
    task automatic advance_model();
        model_prev  = model_now;
        model_now   = model_owner;
        model_owner = (last_cmd != bus_none);
        if (last_halt) begin
            model_halted = 1'b1;
        end
    endtask

    // data request passes live, else a double-word fetch load
    function automatic mem_req_t expected_req();
        mem_req_t req;
        if (model_owner) begin
            req = data_req;
        end else begin
            if (model_halted) begin
                req.command = bus_none;
            end else begin
                req.command = bus_load;
            end
            req.addr = fetch_addr;
            req.data = '0;
            req.size = double_size;
        end
        return req;
    endfunction

    function automatic error_status_t expected_status();
        if (illegal) begin
            return illegal_inst;
        end
        if (model_halted && data_req.command == bus_none) begin
            return halted_on_wfi;
        end
        return no_error;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic row_t make_row(input bus_cmd_t cmd, input logic halt_strobe,
                                      input logic illegal_level, input logic respond);
        row_t row;
        row.cmd           = cmd;
        row.halt_strobe   = halt_strobe;
        row.illegal_level = illegal_level;
        row.respond       = respond;
        return row;
    endfunction

    task automatic build_table();
        // fetch owns the port, responses go to fetch
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        // data load then store, ownership moves across
        stimulus.push_back(make_row(bus_load, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_load, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_store, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_store, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_load, 1'b0, 1'b0, 1'b0));
        // back to fetch, mixed history drops responses
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b1, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        // single-cycle data request
        stimulus.push_back(make_row(bus_store, 1'b0, 1'b0, 1'b0));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        // halt strobe, fetch stops
        stimulus.push_back(make_row(bus_none, 1'b1, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b0));
        stimulus.push_back(make_row(bus_load, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_store, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        // illegal wins over halt
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b1, 1'b1));
        stimulus.push_back(make_row(bus_load, 1'b0, 1'b1, 1'b0));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
        stimulus.push_back(make_row(bus_none, 1'b0, 1'b0, 1'b1));
    endtask

    task automatic drive_inputs(input row_t row);
        fetch_addr       = $urandom;
        data_req.command = row.cmd;
        data_req.addr    = $urandom;
        data_req.data    = {$urandom, $urandom};
        data_req.size    = mem_size_t'($urandom_range(0, 3));
        if (row.respond) begin
            mem_response = mem_tag_t'($urandom_range(1, 15));
        end else begin
            mem_response = no_tag;
        end
        mem_tag   = mem_tag_t'($urandom_range(0, 15));
        mem_rdata = {$urandom, $urandom};
        halt      = row.halt_strobe;
        illegal   = row.illegal_level;
        last_cmd  = row.cmd;
        last_halt = row.halt_strobe;
    endtask

    task automatic check_outputs();
        check_req(mem_req, expected_req(), "mem_req");
        if (model_now && model_prev) begin
            check_tag(data_response, mem_response, "data_response");
        end else begin
            check_tag(data_response, no_tag, "data_response");
        end
        if (!model_now && !model_prev) begin
            check_tag(fetch_response, mem_response, "fetch_response");
        end else begin
            check_tag(fetch_response, no_tag, "fetch_response");
        end
        // fan-out of return data and tag
        check_tag(fetch_tag, mem_tag, "fetch_tag");
        check_tag(data_tag, mem_tag, "data_tag");
        check_line(fetch_rdata, mem_rdata, "fetch_rdata");
        check_line(data_rdata, mem_rdata, "data_rdata");
        check_flag(fetch_stall, model_now, "fetch_stall");
        check_flag(halted, model_halted, "halted");
        check_status(status, expected_status(), "status");
    endtask

    // drive 1 ns after the edge, check mid-cycle
    task automatic run_cycle(input row_t row);
        @(posedge clock);
        advance_model();
        #1;
        drive_inputs(row);
        #4;
        check_outputs();
        step++;
    endtask

    task automatic apply_reset(input int hold_cycles, input int limit);
        int cycles;
        cycles = 0;
        reset  = 1'b1;
        drive_inputs(make_row(bus_none, 1'b0, 1'b0, 1'b0));
        model_owner  = 1'b0;
        model_now    = 1'b0;
        model_prev   = 1'b0;
        model_halted = 1'b0;
        while (reset === 1'b1) begin
            if (cycles >= limit) begin
                abort_run("reset was not released within the cycle limit");
            end
            @(posedge clock);
            cycles++;
            if (cycles == hold_cycles) begin
                #1;
                reset = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        row_t idle_row;
        void'($urandom(47628));
        reset        = 1'b1;
        fetch_addr   = '0;
        data_req     = '0;
        mem_response = '0;
        mem_tag      = '0;
        mem_rdata    = '0;
        halt         = 1'b0;
        illegal      = 1'b0;
        last_cmd     = bus_none;
        last_halt    = 1'b0;
        step         = 0;
        check_count  = 0;
        build_table();
        idle_row = make_row(bus_none, 1'b0, 1'b0, 1'b1);
        apply_reset(2, 20);
        foreach (stimulus[i]) begin
            run_cycle(stimulus[i]);
        end
        // halted clears only on reset
        apply_reset(2, 20);
        repeat (3) run_cycle(idle_row);
        if (check_count > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("no output checks were run");
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/mem_port_pkg.sv
hdl/request_capture.sv
hdl/owner_history.sv
hdl/port_mux.sv
hdl/mem_port_top.sv
sim/mem_port_properties.sv
sim/mem_port_tb.sv
